//--- common/dcache_pkg.sv
package dcache_pkg;

	// Address and data widths seen by the CPU and by memory.
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	// An address splits into tag, set index and byte offset within the line.
	localparam int OFFSET_BITS = 5;
	localparam int SET_BITS = 3;
	localparam int TAG_BITS = ADDR_W - SET_BITS - OFFSET_BITS;
	localparam int NUM_SETS = 1 << SET_BITS;

	// A line holds eight words, which is also the length of every memory burst.
	localparam int LINE_WORDS = 8;
	localparam int LINE_W = LINE_WORDS * WORD_W;
	localparam int BEAT_BITS = $clog2(LINE_WORDS);

	// Controller states, in the order a dirty miss walks through them.
	typedef enum logic [2:0] {
		IDLE,
		WB_REQ,
		WB_SEND,
		FILL_REQ,
		FILL_RECV,
		FILL_WRITE,
		DONE
	} ctrl_state_t;

	function automatic logic [TAG_BITS-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
		return addr[ADDR_W-1 -: TAG_BITS];
	endfunction

	function automatic logic [SET_BITS-1:0] addr_set(input logic [ADDR_W-1:0] addr);
		return addr[OFFSET_BITS +: SET_BITS];
	endfunction

	// Word within the line; the two lowest address bits select a byte and are ignored.
	function automatic logic [BEAT_BITS-1:0] addr_word(input logic [ADDR_W-1:0] addr);
		return addr[2 +: BEAT_BITS];
	endfunction

endpackage

//--- common/cache_lookup_if.sv
`timescale 1ns/1ps

interface cache_lookup_if #(
	parameter int NUM_WAYS = 4
);
	import dcache_pkg::*;

	// Driven by the controller.
	logic [SET_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic lookup_en;
	logic line_we;
	logic mark_dirty;
	logic [LINE_W-1:0] wdata_line;

	// Driven by the tag store.
	logic hit;
	logic [NUM_WAYS-1:0] target_way;
	logic victim_dirty;
	logic [TAG_BITS-1:0] victim_tag;

	// Driven by the line store.
	logic [LINE_W-1:0] rdata_line;

	// The controller never looks at the way itself, only at the line and the victim info.
	modport ctrl (
		output index, tag, lookup_en, line_we, mark_dirty, wdata_line,
		input hit, victim_dirty, victim_tag, rdata_line
	);

	modport tags (
		input index, tag, lookup_en, line_we, mark_dirty,
		output hit, target_way, victim_dirty, victim_tag
	);

	modport lines (
		input index, target_way, line_we, wdata_line,
		output rdata_line
	);

endinterface

//--- dcache/tag_store.sv
`timescale 1ns/1ps

module tag_store #(
	parameter int NUM_WAYS = 4
) (
	input logic clk,
	input logic rst,
	cache_lookup_if.tags lookup
);
	import dcache_pkg::*;

	localparam int AGE_W = $clog2(NUM_WAYS);
	localparam logic [AGE_W-1:0] AGE_OLDEST = AGE_W'(NUM_WAYS - 1);

	logic [TAG_BITS-1:0] tags [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty [NUM_SETS];
	// Age 0 is the most recently used way, AGE_OLDEST the next to go.
	logic [AGE_W-1:0] age [NUM_SETS][NUM_WAYS];

	logic [NUM_WAYS-1:0] hit_vec;
	logic [NUM_WAYS-1:0] victim_oh;
	logic [NUM_WAYS-1:0] live_way;
	logic [NUM_WAYS-1:0] cap_way;
	logic [NUM_WAYS-1:0] sel_way;
	logic [AGE_W-1:0] target_age;

	// A way hits when it is valid and its stored tag equals the request tag.
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_vec[w] = valid[lookup.index][w] && (tags[lookup.index][w] == lookup.tag);
		end
	end

	// The victim is the lowest-numbered way that holds the oldest age.
	always_comb begin : victim_pick
		logic found;
		found = 1'b0;
		victim_oh = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (!found && age[lookup.index][w] == AGE_OLDEST) begin
				victim_oh[w] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign live_way = (|hit_vec) ? hit_vec : victim_oh;

	// The live choice only counts while the controller is accepting a request.
	// Every later cycle of that request works on the way captured then.
	assign sel_way = lookup.lookup_en ? live_way : cap_way;

	always_comb begin
		target_age = '0;
		lookup.victim_tag = '0;
		lookup.victim_dirty = 1'b0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (live_way[w]) begin
				target_age = target_age | age[lookup.index][w];
			end
			if (sel_way[w]) begin
				lookup.victim_tag = lookup.victim_tag | tags[lookup.index][w];
				lookup.victim_dirty = lookup.victim_dirty |
					(valid[lookup.index][w] & dirty[lookup.index][w]);
			end
		end
	end

	assign lookup.hit = |hit_vec;
	assign lookup.target_way = sel_way;

	always_ff @(posedge clk) begin
		if (rst) begin
			cap_way <= '0;
			for (int s = 0; s < NUM_SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				for (int w = 0; w < NUM_WAYS; w++) begin
					age[s][w] <= AGE_OLDEST;
				end
			end
		end else begin
			if (lookup.lookup_en) begin
				cap_way <= live_way;
				// The touched way becomes youngest and everything younger than it moves up one.
				for (int w = 0; w < NUM_WAYS; w++) begin
					if (live_way[w]) begin
						age[lookup.index][w] <= '0;
					end else if (age[lookup.index][w] < target_age) begin
						age[lookup.index][w] <= age[lookup.index][w] + 1'b1;
					end
				end
			end
			if (lookup.line_we) begin
				for (int w = 0; w < NUM_WAYS; w++) begin
					if (sel_way[w]) begin
						valid[lookup.index][w] <= 1'b1;
						dirty[lookup.index][w] <= lookup.mark_dirty;
					end
				end
			end
		end
	end

	// Tags are written together with the line data.
	always_ff @(posedge clk) begin
		if (lookup.line_we) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (sel_way[w]) begin
					tags[lookup.index][w] <= lookup.tag;
				end
			end
		end
	end

endmodule

//--- dcache/line_store.sv
`timescale 1ns/1ps

module line_store #(
	parameter int NUM_WAYS = 4
) (
	input logic clk,
	cache_lookup_if.lines lookup
);
	import dcache_pkg::*;

	// One whole line per way and set.
	logic [LINE_W-1:0] data [NUM_SETS][NUM_WAYS];

	// The target way is one-hot, so an OR over the ways selects its line.
	always_comb begin
		lookup.rdata_line = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (lookup.target_way[w]) begin
				lookup.rdata_line = lookup.rdata_line | data[lookup.index][w];
			end
		end
	end

	// Write hits and refills both replace the complete line.
	always_ff @(posedge clk) begin
		if (lookup.line_we) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (lookup.target_way[w]) begin
					data[lookup.index][w] <= lookup.wdata_line;
				end
			end
		end
	end

endmodule

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic clk,
	input  logic rst,
	cache_lookup_if.ctrl lookup,
	input  logic cpu_req_valid,
	input  logic cpu_req_write,
	input  logic [dcache_pkg::ADDR_W-1:0] cpu_req_addr,
	input  logic [dcache_pkg::WORD_W-1:0] cpu_req_wdata,
	input  logic [dcache_pkg::WORD_W/8-1:0] cpu_req_wstrb,
	output logic cpu_req_ready,
	output logic cpu_rsp_valid,
	output logic [dcache_pkg::WORD_W-1:0] cpu_rsp_data,
	input  logic cpu_rsp_ready,
	output logic mem_rd_req_valid,
	output logic [dcache_pkg::ADDR_W-1:0] mem_rd_req_addr,
	input  logic mem_rd_req_ready,
	input  logic mem_rd_rsp_valid,
	input  logic [dcache_pkg::WORD_W-1:0] mem_rd_rsp_data,
	input  logic mem_rd_rsp_last,
	output logic mem_rd_rsp_ready,
	output logic mem_wr_req_valid,
	output logic [dcache_pkg::ADDR_W-1:0] mem_wr_req_addr,
	input  logic mem_wr_req_ready,
	output logic mem_wr_data_valid,
	output logic [dcache_pkg::WORD_W-1:0] mem_wr_data,
	output logic mem_wr_data_last,
	input  logic mem_wr_data_ready
);
	import dcache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic [ADDR_W-1:0] req_addr;
	logic req_write;
	logic [WORD_W-1:0] req_wdata;
	logic [WORD_W/8-1:0] req_wstrb;
	logic [LINE_W-1:0] buffer;
	logic [BEAT_BITS-1:0] beat_cnt;
	logic [WORD_W-1:0] rsp_data;

	logic idle;
	logic accept;
	logic [ADDR_W-1:0] cur_addr;
	logic [WORD_W-1:0] cur_wdata;
	logic [WORD_W/8-1:0] cur_wstrb;
	logic [BEAT_BITS-1:0] word_sel;
	logic [LINE_W-1:0] base_line;
	logic [LINE_W-1:0] merged_line;
	logic [WORD_W-1:0] merged_word;

	assign idle = (state == IDLE);
	assign accept = idle && cpu_req_valid;

	// In IDLE the request comes straight from the CPU pins; afterwards from the captured copy.
	// Strobes are forced to zero for reads, so the merge then passes the stored word.
	assign cur_addr = idle ? cpu_req_addr : req_addr;
	assign cur_wdata = idle ? cpu_req_wdata : req_wdata;
	assign cur_wstrb = idle ? (cpu_req_wstrb & {(WORD_W/8){cpu_req_write}}) : req_wstrb;
	assign word_sel = addr_word(cur_addr);

	// A hit merges into the stored line, a refill into the freshly received buffer.
	assign base_line = idle ? lookup.rdata_line : buffer;

	always_comb begin
		merged_word = base_line[word_sel*WORD_W +: WORD_W];
		for (int b = 0; b < WORD_W/8; b++) begin
			if (cur_wstrb[b]) begin
				merged_word[8*b +: 8] = cur_wdata[8*b +: 8];
			end
		end
		merged_line = base_line;
		merged_line[word_sel*WORD_W +: WORD_W] = merged_word;
	end

	assign lookup.index = addr_set(cur_addr);
	assign lookup.tag = addr_tag(cur_addr);
	assign lookup.lookup_en = accept;
	assign lookup.line_we = (accept && lookup.hit && cpu_req_write) || (state == FILL_WRITE);
	// A refill after a read miss leaves the line clean.
	assign lookup.mark_dirty = idle ? cpu_req_write : req_write;
	assign lookup.wdata_line = merged_line;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (cpu_req_valid) begin
					if (lookup.hit) begin
						next_state = DONE;
					end else if (lookup.victim_dirty) begin
						next_state = WB_REQ;
					end else begin
						next_state = FILL_REQ;
					end
				end
			end
			WB_REQ: begin
				if (mem_wr_req_ready) begin
					next_state = WB_SEND;
				end
			end
			WB_SEND: begin
				if (mem_wr_data_ready && mem_wr_data_last) begin
					next_state = FILL_REQ;
				end
			end
			FILL_REQ: begin
				if (mem_rd_req_ready) begin
					next_state = FILL_RECV;
				end
			end
			FILL_RECV: begin
				if (mem_rd_rsp_valid && mem_rd_rsp_last) begin
					next_state = FILL_WRITE;
				end
			end
			FILL_WRITE: next_state = DONE;
			default: begin
				// Writes never wait for the CPU; reads hold DONE until the response is taken.
				if (req_write || cpu_rsp_ready) begin
					next_state = IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			beat_cnt <= '0;
		end else begin
			state <= next_state;
			if (accept) begin
				beat_cnt <= '0;
			end else if (state == WB_SEND && mem_wr_data_ready) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// Request capture, line buffer and response word.
	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= cpu_req_addr;
			req_write <= cpu_req_write;
			req_wdata <= cpu_req_wdata;
			req_wstrb <= cpu_req_wstrb & {(WORD_W/8){cpu_req_write}};
		end
		if (accept && !lookup.hit && lookup.victim_dirty) begin
			buffer <= lookup.rdata_line;
		end else if (state == FILL_RECV && mem_rd_rsp_valid) begin
			// Beats arrive lowest word first and shift in from the top.
			buffer <= {mem_rd_rsp_data, buffer[LINE_W-1:WORD_W]};
		end
		if ((accept && lookup.hit) || state == FILL_WRITE) begin
			rsp_data <= merged_word;
		end
	end

	assign cpu_req_ready = idle;
	assign cpu_rsp_valid = (state == DONE) && !req_write;
	assign cpu_rsp_data = rsp_data;

	assign mem_rd_req_valid = (state == FILL_REQ);
	assign mem_rd_req_addr = {cur_addr[ADDR_W-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign mem_rd_rsp_ready = (state == FILL_RECV);

	// The victim line lives at its own tag under the same set index.
	assign mem_wr_req_valid = (state == WB_REQ);
	assign mem_wr_req_addr = {lookup.victim_tag, lookup.index, {OFFSET_BITS{1'b0}}};
	assign mem_wr_data_valid = (state == WB_SEND);
	assign mem_wr_data = buffer[beat_cnt*WORD_W +: WORD_W];
	assign mem_wr_data_last = (state == WB_SEND) && (beat_cnt == BEAT_BITS'(LINE_WORDS - 1));

endmodule

//--- dcache/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
	parameter int NUM_WAYS = 4
) (
	input  logic clk,
	input  logic rst,

	// CPU request and response.
	input  logic cpu_req_valid,
	input  logic cpu_req_write,
	input  logic [dcache_pkg::ADDR_W-1:0] cpu_req_addr,
	input  logic [dcache_pkg::WORD_W-1:0] cpu_req_wdata,
	input  logic [dcache_pkg::WORD_W/8-1:0] cpu_req_wstrb,
	output logic cpu_req_ready,
	output logic cpu_rsp_valid,
	output logic [dcache_pkg::WORD_W-1:0] cpu_rsp_data,
	input  logic cpu_rsp_ready,

	// Memory read channel, used for refills.
	output logic mem_rd_req_valid,
	output logic [dcache_pkg::ADDR_W-1:0] mem_rd_req_addr,
	input  logic mem_rd_req_ready,
	input  logic mem_rd_rsp_valid,
	input  logic [dcache_pkg::WORD_W-1:0] mem_rd_rsp_data,
	input  logic mem_rd_rsp_last,
	output logic mem_rd_rsp_ready,

	// Memory write channel, used for write-backs of dirty victims.
	output logic mem_wr_req_valid,
	output logic [dcache_pkg::ADDR_W-1:0] mem_wr_req_addr,
	input  logic mem_wr_req_ready,
	output logic mem_wr_data_valid,
	output logic [dcache_pkg::WORD_W-1:0] mem_wr_data,
	output logic mem_wr_data_last,
	input  logic mem_wr_data_ready
);

	cache_lookup_if #(.NUM_WAYS(NUM_WAYS)) lookup ();

	// The controller runs the request and both memory channels.
	dcache_ctrl i_ctrl (
		.clk(clk),
		.rst(rst),
		.lookup(lookup.ctrl),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req_write(cpu_req_write),
		.cpu_req_addr(cpu_req_addr),
		.cpu_req_wdata(cpu_req_wdata),
		.cpu_req_wstrb(cpu_req_wstrb),
		.cpu_req_ready(cpu_req_ready),
		.cpu_rsp_valid(cpu_rsp_valid),
		.cpu_rsp_data(cpu_rsp_data),
		.cpu_rsp_ready(cpu_rsp_ready),
		.mem_rd_req_valid(mem_rd_req_valid),
		.mem_rd_req_addr(mem_rd_req_addr),
		.mem_rd_req_ready(mem_rd_req_ready),
		.mem_rd_rsp_valid(mem_rd_rsp_valid),
		.mem_rd_rsp_data(mem_rd_rsp_data),
		.mem_rd_rsp_last(mem_rd_rsp_last),
		.mem_rd_rsp_ready(mem_rd_rsp_ready),
		.mem_wr_req_valid(mem_wr_req_valid),
		.mem_wr_req_addr(mem_wr_req_addr),
		.mem_wr_req_ready(mem_wr_req_ready),
		.mem_wr_data_valid(mem_wr_data_valid),
		.mem_wr_data(mem_wr_data),
		.mem_wr_data_last(mem_wr_data_last),
		.mem_wr_data_ready(mem_wr_data_ready)
	);

	// Tags, state bits and the age order; it also picks the way in use.
	tag_store #(.NUM_WAYS(NUM_WAYS)) i_tag_store (
		.clk(clk),
		.rst(rst),
		.lookup(lookup.tags)
	);

	line_store #(.NUM_WAYS(NUM_WAYS)) i_line_store (
		.clk(clk),
		.lookup(lookup.lines)
	);

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD_NS = 5,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst
);

	// Free-running clock with a 10 ns period.
	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD_NS clk = ~clk;
		end
	end

	// Reset is released on a falling edge, like every other stimulus.
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- sim/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
	import dcache_pkg::*;

	localparam int FIELDS = 7;
	localparam int MAX_OPS = 64;

	logic clk;
	logic rst;
	logic cpu_req_valid;
	logic cpu_req_write;
	logic [ADDR_W-1:0] cpu_req_addr;
	logic [WORD_W-1:0] cpu_req_wdata;
	logic [WORD_W/8-1:0] cpu_req_wstrb;
	logic cpu_req_ready;
	logic cpu_rsp_valid;
	logic [WORD_W-1:0] cpu_rsp_data;
	logic cpu_rsp_ready = 1'b0;
	logic mem_rd_req_valid;
	logic [ADDR_W-1:0] mem_rd_req_addr;
	logic mem_rd_req_ready = 1'b0;
	logic mem_rd_rsp_valid = 1'b0;
	logic [WORD_W-1:0] mem_rd_rsp_data = '0;
	logic mem_rd_rsp_last = 1'b0;
	logic mem_rd_rsp_ready;
	logic mem_wr_req_valid;
	logic [ADDR_W-1:0] mem_wr_req_addr;
	logic mem_wr_req_ready = 1'b0;
	logic mem_wr_data_valid;
	logic [WORD_W-1:0] mem_wr_data;
	logic mem_wr_data_last;
	logic mem_wr_data_ready = 1'b0;

	// Seven words per operation: op, address, wdata, strobe, expected word, bursts.
	logic [31:0] golden [MAX_OPS*FIELDS];
	// Words written back by the DUT; all others still hold the fill pattern.
	logic [31:0] mem_words [logic [31:0]];

	integer seed = 32'hcc91;
	int cycles = 0;
	int timeout_cycles;
	int num_ops;
	int errors;
	int failed_ops;
	int protocol_errors;
	int wb_bursts;
	int fill_bursts;
	logic rd_active;
	logic rd_taken;
	logic [ADDR_W-1:0] rd_addr;
	int rd_beat;
	logic wr_active;
	logic [ADDR_W-1:0] wr_addr;
	int wr_beat;
	ctrl_state_t ctrl_state;

	tb_clock i_clock (
		.clk(clk),
		.rst(rst)
	);

	dcache_top i_dcache_top (.*);

	// Only used to name the state in a timeout message.
	assign ctrl_state = i_dcache_top.i_ctrl.state;

	// Untouched memory holds its own address with the upper half scrambled.
	function automatic logic [31:0] mem_read(input logic [31:0] addr);
		if (mem_words.exists(addr)) begin
			return mem_words[addr];
		end
		return addr ^ 32'h5a5a0000;
	endfunction

	// A ready is given three times out of four.
	function automatic logic random_ready();
		return ($random(seed) & 3) != 0;
	endfunction

	// Handshakes are sampled at the rising edge, before the DUT registers update.
	always @(posedge clk) begin
		if (rst) begin
			rd_active = 1'b0;
			rd_taken = 1'b0;
			rd_addr = '0;
			rd_beat = 0;
			wr_active = 1'b0;
			wr_addr = '0;
			wr_beat = 0;
		end else begin
			if (mem_rd_req_valid && mem_rd_req_ready) begin
				rd_active = 1'b1;
				rd_addr = mem_rd_req_addr;
				rd_beat = 0;
				fill_bursts++;
			end
			rd_taken = mem_rd_rsp_valid && mem_rd_rsp_ready;
			if (rd_taken) begin
				rd_beat++;
				if (rd_beat == LINE_WORDS) begin
					rd_active = 1'b0;
				end
			end
			if (mem_wr_req_valid && mem_wr_req_ready) begin
				if (wr_active) begin
					$display("A write-back request arrived before the previous burst ended");
					protocol_errors++;
				end
				wr_active = 1'b1;
				wr_addr = mem_wr_req_addr;
				wr_beat = 0;
				wb_bursts++;
			end
			if (mem_wr_data_valid && mem_wr_data_ready) begin
				if (!wr_active) begin
					$display("A write-back data beat arrived without a write request");
					protocol_errors++;
				end else begin
					mem_words[wr_addr + 4 * wr_beat] = mem_wr_data;
					wr_beat++;
					// The last flag has to come with the eighth beat and no other.
					if (mem_wr_data_last != (wr_beat == LINE_WORDS)) begin
						$display("Write-back last flag wrong on beat %0d of %h", wr_beat, wr_addr);
						protocol_errors++;
					end
					if (mem_wr_data_last) begin
						wr_active = 1'b0;
					end
				end
			end
		end
	end

	// Memory-side inputs change on the falling edge only.
	always @(negedge clk) begin
		mem_rd_req_ready = random_ready();
		mem_wr_req_ready = random_ready();
		mem_wr_data_ready = random_ready();
		cpu_rsp_ready = random_ready();
		// A beat that was offered and not taken stays as it is.
		if (!mem_rd_rsp_valid || rd_taken) begin
			mem_rd_rsp_valid = rd_active && random_ready();
			mem_rd_rsp_data = mem_read(rd_addr + 4 * rd_beat);
			mem_rd_rsp_last = (rd_beat == LINE_WORDS - 1);
		end
	end

	// Reset length plus a generous bound per operation.
	always @(posedge clk) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			$display("Timeout after %0d cycles with the controller in state %s",
				cycles, ctrl_state.name());
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic run_op(input int n);
		int base;
		string name;
		logic is_write;
		logic [31:0] addr;
		logic [31:0] expected;
		logic [31:0] actual;
		int exp_wb;
		int exp_fill;
		int wb_start;
		int fill_start;
		int err_start;
		base = n * FIELDS;
		name = $sformatf("op%0d", n);
		is_write = golden[base][0];
		addr = golden[base+1];
		expected = golden[base+4];
		exp_wb = golden[base+5];
		exp_fill = golden[base+6];
		actual = '0;
		@(negedge clk);
		wb_start = wb_bursts;
		fill_start = fill_bursts;
		err_start = errors + protocol_errors;
		cpu_req_valid = 1'b1;
		cpu_req_write = is_write;
		cpu_req_addr = addr;
		cpu_req_wdata = golden[base+2];
		cpu_req_wstrb = golden[base+3][3:0];
		do begin
			@(posedge clk);
		end while (!cpu_req_ready);
		@(negedge clk);
		cpu_req_valid = 1'b0;
		// A write ends when the cache is ready again; a read ends with its response.
		if (is_write) begin
			do begin
				@(posedge clk);
			end while (!cpu_req_ready);
		end else begin
			do begin
				@(posedge clk);
			end while (!(cpu_rsp_valid && cpu_rsp_ready));
			actual = cpu_rsp_data;
		end
		if (!is_write && actual !== expected) begin
			$display("ERROR %s read data: expected %h, actual %h", name, expected, actual);
			errors++;
		end
		if (wb_bursts - wb_start != exp_wb) begin
			$display("ERROR %s write-back bursts: expected %0d, actual %0d",
				name, exp_wb, wb_bursts - wb_start);
			errors++;
		end
		if (fill_bursts - fill_start != exp_fill) begin
			$display("ERROR %s refill bursts: expected %0d, actual %0d",
				name, exp_fill, fill_bursts - fill_start);
			errors++;
		end
		if (errors + protocol_errors == err_start) begin
			$display("%s %s %h ok", name, is_write ? "write" : "read", addr);
		end else begin
			failed_ops++;
			$display("%s %s %h failed", name, is_write ? "write" : "read", addr);
		end
	endtask

	initial begin
		errors = 0;
		failed_ops = 0;
		protocol_errors = 0;
		wb_bursts = 0;
		fill_bursts = 0;
		cpu_req_valid = 1'b0;
		cpu_req_write = 1'b0;
		cpu_req_addr = '0;
		cpu_req_wdata = '0;
		cpu_req_wstrb = '0;
		// Unread entries keep all ones, which marks the end of the table.
		for (int i = 0; i < MAX_OPS * FIELDS; i++) begin
			golden[i] = '1;
		end
		$readmemh("sim/dcache_golden.txt", golden);
		num_ops = 0;
		while (num_ops < MAX_OPS && golden[num_ops*FIELDS] != '1) begin
			num_ops++;
		end
		timeout_cycles = 16 + 80 * num_ops;
		if (num_ops == 0) begin
			$display("No operations were read from the golden file");
			errors++;
		end
		@(negedge rst);
		for (int n = 0; n < num_ops; n++) begin
			run_op(n);
		end
		$display("%0d operations: %0d passed, %0d failed, %0d errors",
			num_ops, num_ops - failed_ops, failed_ops, errors + protocol_errors);
		if (errors + protocol_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- sim/dcache_golden.txt
// op addr wdata wstrb expected_rdata wb_bursts fill_bursts (op 0 read, 1 write)
// All fields hex; expected_rdata is ignored for writes.
0 00001024 00000000 0 5a5a1024 0 1
0 0000103c 00000000 0 5a5a103c 0 0
1 00001028 deadbeef 5 00000000 0 0
0 00001028 00000000 0 5aad10ef 0 0
1 00002044 12345678 c 00000000 0 1
0 00002044 00000000 0 12342044 0 0
0 00003060 00000000 0 5a5a3060 0 1
0 00004064 00000000 0 5a5a4064 0 1
0 00005068 00000000 0 5a5a5068 0 1
0 0000606c 00000000 0 5a5a606c 0 1
0 00003070 00000000 0 5a5a3070 0 0
0 00007074 00000000 0 5a5a7074 0 1
0 00003060 00000000 0 5a5a3060 0 0
0 00004064 00000000 0 5a5a4064 0 1
1 00008084 cafef00d f 00000000 0 1
0 00009080 00000000 0 5a5a9080 0 1
0 0000a080 00000000 0 5a5aa080 0 1
0 0000b080 00000000 0 5a5ab080 0 1
0 0000c088 00000000 0 5a5ac088 1 1
0 00008084 00000000 0 cafef00d 0 1
0 00008080 00000000 0 5a5a8080 0 0

//--- src.f
common/dcache_pkg.sv
common/cache_lookup_if.sv
dcache/tag_store.sv
dcache/line_store.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
sim/tb_clock.sv
sim/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP := dcache_tb
FILELIST := src.f
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "All tests passed" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
